//--- common/cam_display_pkg.sv
// display path shared definitions
package cam_display_pkg;

    // frame buffer addressing
    localparam int PIX_ADDR_W = 17;               // enough for 320x240 = 76800
    localparam int CHANNEL_W  = 8;                // one output color channel

    // linear pixel address, row major over the stored image
    typedef logic [PIX_ADDR_W-1:0] pix_addr_t;

    // stored pixel layout, red in the top bits
    typedef struct packed {
        logic [4:0] red;                          // bits 15:11
        logic [5:0] green;                        // bits 10:5
        logic [4:0] blue;                         // bits 4:0
    } rgb565_t;

    // expanded output channel
    typedef logic [CHANNEL_W-1:0] channel_t;

    // what the output stage puts on the vga pins
    typedef enum logic {
        MODE_COLOR = 1'b0,                        // expanded rgb888
        MODE_GRAY  = 1'b1                         // gray on all three channels
    } display_mode_e;

    // luma weights, scaled by 256
    localparam int GRAY_W_R = 76;                 // ~0.299
    localparam int GRAY_W_G = 150;                // ~0.587
    localparam int GRAY_W_B = 30;                 // ~0.114

    // weights add up to 256, so the sum is normalized by this shift
    localparam int GRAY_SHIFT = 8;

endpackage

//--- source/raster_timing.sv
// vga raster timing and frame buffer read address
module raster_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                      clk_25_vga,
    input  logic                      arst_n,
    output cam_display_pkg::pix_addr_t rd_addr,   // address of the registered position
    output logic                      active,     // inside the visible area
    output logic                      hsync,      // active low
    output logic                      vsync       // active low
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_W     = $clog2(H_TOTAL);
    localparam int V_W     = $clog2(V_TOTAL);

    // sized counter limits
    localparam logic [H_W-1:0] H_LAST     = H_W'(H_TOTAL - 1);
    localparam logic [H_W-1:0] H_ACT      = H_W'(H_ACTIVE);
    localparam logic [H_W-1:0] H_SYNC_BEG = H_W'(H_ACTIVE + H_FRONT);
    localparam logic [H_W-1:0] H_SYNC_END = H_W'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [V_W-1:0] V_LAST     = V_W'(V_TOTAL - 1);
    localparam logic [V_W-1:0] V_ACT      = V_W'(V_ACTIVE);
    localparam logic [V_W-1:0] V_SYNC_BEG = V_W'(V_ACTIVE + V_FRONT);
    localparam logic [V_W-1:0] V_SYNC_END = V_W'(V_ACTIVE + V_FRONT + V_SYNC);

    // stored image is half the screen in each direction
    localparam cam_display_pkg::pix_addr_t IMG_PIXELS =
        cam_display_pkg::pix_addr_t'((H_ACTIVE / 2) * (V_ACTIVE / 2));

    logic [H_W-1:0]             h_cnt;            // current column
    logic [V_W-1:0]             v_cnt;            // current line
    cam_display_pkg::pix_addr_t addr_cnt;         // address of (h_cnt, v_cnt)
    cam_display_pkg::pix_addr_t line_base;        // first address of the image row
    logic                       in_active;

    assign in_active = (h_cnt < H_ACT) && (v_cnt < V_ACT);

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt     <= '0;                      // start at top left of a frame
            v_cnt     <= '0;
            addr_cnt  <= '0;
            line_base <= '0;
        end else begin
            if (h_cnt == H_LAST) begin
                h_cnt <= '0;
                if (v_cnt == V_LAST) begin
                    v_cnt     <= '0;              // frame wrap
                    addr_cnt  <= '0;
                    line_base <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                    if (!v_cnt[0]) begin
                        addr_cnt <= line_base;    // even line, repeat the image row
                    end else begin
                        line_base <= addr_cnt;    // odd line done, next row starts here
                    end
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
                if (in_active && h_cnt[0]) begin
                    addr_cnt <= addr_cnt + 1'b1;  // step every second column
                end
            end
        end
    end

    // stage 1 outputs
    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            rd_addr <= '0;
            active  <= 1'b0;
            hsync   <= 1'b1;                      // syncs idle high
            vsync   <= 1'b1;
        end else begin
            rd_addr <= addr_cnt;
            active  <= in_active;
            hsync   <= !((h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END));
            vsync   <= !((v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END));
        end
    end

    // the increment scheme must never run past the stored image
    assert property (@(posedge clk_25_vga) disable iff (!arst_n)
        active |-> (rd_addr < IMG_PIXELS))
        else $error("raster read address outside the image");

endmodule

//--- frame_buffer/frame_buffer_bank.sv
// one frame buffer bank, simple dual port
module frame_buffer_bank #(
    parameter int DEPTH = 32768
) (
    input  logic                       clk_25_vga,
    input  logic                       wr_en,
    input  cam_display_pkg::pix_addr_t wr_index,
    input  cam_display_pkg::rgb565_t   wr_data,
    input  cam_display_pkg::pix_addr_t rd_index,
    output cam_display_pkg::rgb565_t   rd_data    // valid one clock after rd_index
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    cam_display_pkg::rgb565_t mem [DEPTH];        // block ram on fpga

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // bank only decodes its own depth
    assign wr_idx = wr_index[IDX_W-1:0];
    assign rd_idx = rd_index[IDX_W-1:0];

    // write port
    always_ff @(posedge clk_25_vga) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // registered read, new data shows after a same address write
    always_ff @(posedge clk_25_vga) begin
        rd_data <= mem[rd_idx];
    end

endmodule

//--- frame_buffer/frame_buffer.sv
// two bank frame buffer with flag alignment
module frame_buffer #(
    parameter int FRAME_PIXELS = 76800,
    parameter int BANK_SPLIT   = 32768
) (
    input  logic                       clk_25_vga,
    input  logic                       arst_n,
    input  logic                       wr_en,      // plain strobe, no ack
    input  cam_display_pkg::pix_addr_t wr_addr,
    input  cam_display_pkg::rgb565_t   wr_data,
    input  cam_display_pkg::pix_addr_t rd_addr,
    input  logic                       active_in,
    input  logic                       hsync_in,
    input  logic                       vsync_in,
    output cam_display_pkg::rgb565_t   pixel,      // aligned with the flags below
    output logic                       active,
    output logic                       hsync,
    output logic                       vsync
);

    localparam cam_display_pkg::pix_addr_t SPLIT_ADDR =
        cam_display_pkg::pix_addr_t'(BANK_SPLIT);
    localparam cam_display_pkg::pix_addr_t FRAME_ADDR =
        cam_display_pkg::pix_addr_t'(FRAME_PIXELS);

    logic                       wr_hi;            // write hits bank 1
    logic                       rd_hi;            // read hits bank 1
    logic                       rd_hi_q;          // bank select lined up with ram output
    cam_display_pkg::pix_addr_t wr_index_hi;
    cam_display_pkg::pix_addr_t rd_index_hi;
    cam_display_pkg::rgb565_t   rd_data_lo;
    cam_display_pkg::rgb565_t   rd_data_hi;

    assign wr_hi       = (wr_addr >= SPLIT_ADDR);
    assign rd_hi       = (rd_addr >= SPLIT_ADDR);
    assign wr_index_hi = wr_addr - SPLIT_ADDR;    // bank 1 starts at index 0
    assign rd_index_hi = rd_addr - SPLIT_ADDR;

    frame_buffer_bank #(
        .DEPTH(BANK_SPLIT)
    ) bank_lo (
        .clk_25_vga(clk_25_vga),
        .wr_en     (wr_en && !wr_hi),
        .wr_index  (wr_addr),
        .wr_data   (wr_data),
        .rd_index  (rd_addr),
        .rd_data   (rd_data_lo)
    );

    frame_buffer_bank #(
        .DEPTH(FRAME_PIXELS - BANK_SPLIT)
    ) bank_hi (
        .clk_25_vga(clk_25_vga),
        .wr_en     (wr_en && wr_hi),
        .wr_index  (wr_index_hi),
        .wr_data   (wr_data),
        .rd_index  (rd_index_hi),
        .rd_data   (rd_data_hi)
    );

    // stage 2 control, same clock as the ram read
    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            rd_hi_q <= 1'b0;
            active  <= 1'b0;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
        end else begin
            rd_hi_q <= rd_hi;
            active  <= active_in;
            hsync   <= hsync_in;
            vsync   <= vsync_in;
        end
    end

    assign pixel = rd_hi_q ? rd_data_hi : rd_data_lo;

    // writes beyond the image would alias into a bank
    assert property (@(posedge clk_25_vga) disable iff (!arst_n)
        wr_en |-> (wr_addr < FRAME_ADDR))
        else $error("frame buffer write beyond the image");

endmodule

//--- source/pixel_color.sv
// rgb565 expansion and gray value
module pixel_color (
    input  logic                      clk_25_vga,
    input  logic                      arst_n,
    input  cam_display_pkg::rgb565_t  pixel,
    input  logic                      active_in,
    input  logic                      hsync_in,
    input  logic                      vsync_in,
    output cam_display_pkg::channel_t red,
    output cam_display_pkg::channel_t green,
    output cam_display_pkg::channel_t blue,
    output cam_display_pkg::channel_t gray,
    output logic                      active,
    output logic                      hsync,
    output logic                      vsync
);

    // 255 * 256 fits, one spare bit on top
    typedef logic [16:0] sum_t;

    cam_display_pkg::channel_t red_x;
    cam_display_pkg::channel_t green_x;
    cam_display_pkg::channel_t blue_x;
    sum_t                      gray_sum;
    cam_display_pkg::channel_t gray_x;

    // msbs copied into the low bits, full scale maps to 255
    assign red_x   = {pixel.red,   pixel.red[4:2]};
    assign green_x = {pixel.green, pixel.green[5:4]};
    assign blue_x  = {pixel.blue,  pixel.blue[4:2]};

    // weighted sum on the expanded channels
    assign gray_sum = sum_t'(cam_display_pkg::GRAY_W_R) * sum_t'(red_x)
                    + sum_t'(cam_display_pkg::GRAY_W_G) * sum_t'(green_x)
                    + sum_t'(cam_display_pkg::GRAY_W_B) * sum_t'(blue_x);

    assign gray_x = cam_display_pkg::channel_t'(gray_sum >> cam_display_pkg::GRAY_SHIFT);

    // stage 3 data
    always_ff @(posedge clk_25_vga) begin
        red   <= red_x;
        green <= green_x;
        blue  <= blue_x;
        gray  <= gray_x;
    end

    // stage 3 flags
    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            hsync  <= 1'b1;
            vsync  <= 1'b1;
        end else begin
            active <= active_in;
            hsync  <= hsync_in;
            vsync  <= vsync_in;
        end
    end

endmodule

//--- source/output_select.sv
// color or gray select and vga output registers
module output_select (
    input  logic                           clk_25_vga,
    input  logic                           arst_n,
    input  cam_display_pkg::display_mode_e mode,
    input  cam_display_pkg::channel_t      red,
    input  cam_display_pkg::channel_t      green,
    input  cam_display_pkg::channel_t      blue,
    input  cam_display_pkg::channel_t      gray,
    input  logic                           active_in,
    input  logic                           hsync_in,
    input  logic                           vsync_in,
    output cam_display_pkg::channel_t      vga_r,
    output cam_display_pkg::channel_t      vga_g,
    output cam_display_pkg::channel_t      vga_b,
    output logic                           vga_hsync,
    output logic                           vga_vsync,
    output logic                           vga_blank_n
);

    cam_display_pkg::display_mode_e mode_q;       // sampled every clock
    cam_display_pkg::channel_t      sel_r;
    cam_display_pkg::channel_t      sel_g;
    cam_display_pkg::channel_t      sel_b;

    always_comb begin
        sel_r = '0;                               // blank outside the active area
        sel_g = '0;
        sel_b = '0;
        if (active_in) begin
            case (mode_q)
                cam_display_pkg::MODE_GRAY: begin
                    sel_r = gray;
                    sel_g = gray;
                    sel_b = gray;
                end
                default: begin
                    sel_r = red;
                    sel_g = green;
                    sel_b = blue;
                end
            endcase
        end
    end

    // stage 4 registers on the pins
    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            mode_q      <= cam_display_pkg::MODE_COLOR;
            vga_r       <= '0;
            vga_g       <= '0;
            vga_b       <= '0;
            vga_hsync   <= 1'b1;
            vga_vsync   <= 1'b1;
            vga_blank_n <= 1'b0;
        end else begin
            mode_q      <= mode;
            vga_r       <= sel_r;
            vga_g       <= sel_g;
            vga_b       <= sel_b;
            vga_hsync   <= hsync_in;
            vga_vsync   <= vsync_in;
            vga_blank_n <= active_in;             // blank travels with the data
        end
    end

endmodule

//--- source/cam_display_top.sv
// frame buffer to vga display top level
module cam_display_top #(
    parameter int H_ACTIVE   = 640,
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int V_ACTIVE   = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter int BANK_SPLIT = 32768
) (
    input  logic                           clk_25_vga,
    input  logic                           arst_n,
    input  logic                           wr_en,
    input  cam_display_pkg::pix_addr_t     wr_addr,
    input  cam_display_pkg::rgb565_t       wr_data,
    input  cam_display_pkg::display_mode_e mode,
    output cam_display_pkg::channel_t      vga_r,
    output cam_display_pkg::channel_t      vga_g,
    output cam_display_pkg::channel_t      vga_b,
    output logic                           vga_hsync,
    output logic                           vga_vsync,
    output logic                           vga_blank_n
);

    // each stored pixel covers 2x2 screen pixels
    localparam int FRAME_PIXELS = (H_ACTIVE / 2) * (V_ACTIVE / 2);

    cam_display_pkg::pix_addr_t rd_addr;
    logic                       rt_active, rt_hsync, rt_vsync;   // stage 1
    cam_display_pkg::rgb565_t   fb_pixel;
    logic                       fb_active, fb_hsync, fb_vsync;   // stage 2
    cam_display_pkg::channel_t  pc_red, pc_green, pc_blue, pc_gray;
    logic                       pc_active, pc_hsync, pc_vsync;   // stage 3

    raster_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_raster (
        .clk_25_vga(clk_25_vga), .arst_n(arst_n), .rd_addr(rd_addr),
        .active(rt_active), .hsync(rt_hsync), .vsync(rt_vsync)
    );

    frame_buffer #(
        .FRAME_PIXELS(FRAME_PIXELS), .BANK_SPLIT(BANK_SPLIT)
    ) u_frame_buffer (
        .clk_25_vga(clk_25_vga), .arst_n(arst_n),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .rd_addr(rd_addr),
        .active_in(rt_active), .hsync_in(rt_hsync), .vsync_in(rt_vsync),
        .pixel(fb_pixel), .active(fb_active), .hsync(fb_hsync), .vsync(fb_vsync)
    );

    pixel_color u_pixel_color (
        .clk_25_vga(clk_25_vga), .arst_n(arst_n), .pixel(fb_pixel),
        .active_in(fb_active), .hsync_in(fb_hsync), .vsync_in(fb_vsync),
        .red(pc_red), .green(pc_green), .blue(pc_blue), .gray(pc_gray),
        .active(pc_active), .hsync(pc_hsync), .vsync(pc_vsync)
    );

    output_select u_output_select (
        .clk_25_vga(clk_25_vga), .arst_n(arst_n), .mode(mode),
        .red(pc_red), .green(pc_green), .blue(pc_blue), .gray(pc_gray),
        .active_in(pc_active), .hsync_in(pc_hsync), .vsync_in(pc_vsync),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
        .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_blank_n(vga_blank_n)
    );

endmodule

//--- test/tb_clock_gen.sv
// testbench clock and reset
module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_25_vga,
    output logic arst_n
);

    initial begin
        clk_25_vga = 1'b0;
        forever #(PERIOD / 2) clk_25_vga = ~clk_25_vga;
    end

    initial begin
        arst_n = 1'b1;                            // start high so a falling edge resets
        #1 arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_25_vga);
        arst_n <= 1'b1;                           // release on a rising edge
    end

endmodule

//--- test/tb_cam_display.sv
// display path testbench
module tb_cam_display;

    // small raster with an 8x6 stored image across the bank split
    localparam int H_ACTIVE     = 16;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 3;
    localparam int H_BACK       = 3;
    localparam int V_ACTIVE     = 12;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 2;
    localparam int BANK_SPLIT   = 32;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int IMG_W        = H_ACTIVE / 2;
    localparam int IMG_PIXELS   = IMG_W * (V_ACTIVE / 2);
    localparam int NUM_ROWS     = 9;

    typedef struct packed {
        cam_display_pkg::rgb565_t pix;
        cam_display_pkg::channel_t exp_r;
        cam_display_pkg::channel_t exp_g;
        cam_display_pkg::channel_t exp_b;
        cam_display_pkg::channel_t exp_gray;
    } row_t;

    logic                           clk_25_vga;
    logic                           arst_n;
    logic                           wr_en;
    cam_display_pkg::pix_addr_t     wr_addr;
    cam_display_pkg::rgb565_t       wr_data;
    cam_display_pkg::display_mode_e mode;
    cam_display_pkg::channel_t      vga_r;
    cam_display_pkg::channel_t      vga_g;
    cam_display_pkg::channel_t      vga_b;
    logic                           vga_hsync;
    logic                           vga_vsync;
    logic                           vga_blank_n;

    row_t        rows [NUM_ROWS];                 // stimulus and expected values
    logic [15:0] lfsr_state;

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(2)) clock0 (
        .clk_25_vga(clk_25_vga),
        .arst_n    (arst_n)
    );

    cam_display_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .BANK_SPLIT(BANK_SPLIT)
    ) dut0 (
        .clk_25_vga(clk_25_vga), .arst_n(arst_n),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .mode(mode),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
        .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_blank_n(vga_blank_n)
    );

    task automatic report_error(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_channel(input string what, input cam_display_pkg::channel_t got,
                                 input cam_display_pkg::channel_t exp);
        if (got !== exp) begin
            report_error($sformatf("error at %0t: %s got %0d expected %0d",
                                   $time, what, got, exp));
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("error at %0t: %s got %b expected %b",
                                   $time, what, got, exp));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            report_error($sformatf("error at %0t: %s got %0d expected %0d",
                                   $time, what, got, exp));
        end
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic draw_random_word(output logic [15:0] word);
        for (int i = 0; i < 16; i++) begin
            word[i]    = lfsr_state[0];           // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // top bits repeated below the field
    function automatic int widen_field(input int value, input int width);
        return (value << (8 - width)) | (value >> (2 * width - 8));
    endfunction

    task automatic set_row(input int idx, input logic [15:0] pix, input int r, input int g,
                           input int b, input int gray);
        rows[idx].pix      = pix;
        rows[idx].exp_r    = cam_display_pkg::channel_t'(r);
        rows[idx].exp_g    = cam_display_pkg::channel_t'(g);
        rows[idx].exp_b    = cam_display_pkg::channel_t'(b);
        rows[idx].exp_gray = cam_display_pkg::channel_t'(gray);
    endtask

    task automatic build_table();
        logic [15:0] word;
        int          r;
        int          g;
        int          b;
        set_row(0, 16'h0000, 0, 0, 0, 0);         // black
        set_row(1, 16'hFFFF, 255, 255, 255, 255); // white
        set_row(2, 16'hF800, 255, 0, 0, 75);
        set_row(3, 16'h07E0, 0, 255, 0, 149);
        set_row(4, 16'h001F, 0, 0, 255, 29);
        set_row(5, 16'h8410, 132, 130, 132, 130); // mid gray
        set_row(6, 16'h3A6B, 57, 77, 90, 72);
        lfsr_state = 16'd9;
        for (int n = 1; n <= 10; n++) begin
            draw_random_word(word);
            if (n >= 9) begin                     // keep words 9 and 10
                r = widen_field(int'(word[15:11]), 5);
                g = widen_field(int'(word[10:5]), 6);
                b = widen_field(int'(word[4:0]), 5);
                set_row(n - 2, word, r, g, b, (cam_display_pkg::GRAY_W_R * r
                        + cam_display_pkg::GRAY_W_G * g + cam_display_pkg::GRAY_W_B * b) >> 8);
            end
        end
    endtask

    task automatic check_reset_state();
        int waited;
        @(negedge clk_25_vga);                    // still in reset
        check_level("hsync in reset", vga_hsync, 1'b1);
        check_level("vsync in reset", vga_vsync, 1'b1);
        check_level("blank_n in reset", vga_blank_n, 1'b0);
        waited = 0;
        while (arst_n !== 1'b1) begin
            @(negedge clk_25_vga);
            waited++;
            if (waited > 8) begin
                report_error("timeout waiting for reset release");
            end
        end
        check_level("hsync after reset", vga_hsync, 1'b1);
        check_level("vsync after reset", vga_vsync, 1'b1);
        check_level("blank_n after reset", vga_blank_n, 1'b0);
        check_channel("red after reset", vga_r, '0);
    endtask

    task automatic load_image();
        for (int p = 0; p < IMG_PIXELS; p++) begin
            @(posedge clk_25_vga);
            wr_en   <= 1'b1;
            wr_addr <= cam_display_pkg::pix_addr_t'(p);
            wr_data <= rows[p % NUM_ROWS].pix;
        end
        @(posedge clk_25_vga);
        wr_en <= 1'b0;
    endtask

    task automatic wait_vsync_fall();
        logic prev;
        int   waited;
        waited = 0;
        @(negedge clk_25_vga);
        prev = vga_vsync;
        forever begin
            @(negedge clk_25_vga);
            if (prev && !vga_vsync) begin
                return;
            end
            prev = vga_vsync;
            waited++;
            if (waited > FRAME_CYCLES + 8) begin
                report_error("timeout waiting for vga_vsync to fall");
            end
        end
    endtask

    task automatic check_pixel(input int x, input int y, input bit show_gray);
        int   addr;
        row_t row;
        addr = (y / 2) * IMG_W + (x / 2);         // 2x2 pixel doubling
        row  = rows[addr % NUM_ROWS];
        check_channel($sformatf("red at (%0d,%0d)", x, y), vga_r,
                      show_gray ? row.exp_gray : row.exp_r);
        check_channel($sformatf("green at (%0d,%0d)", x, y), vga_g,
                      show_gray ? row.exp_gray : row.exp_g);
        check_channel($sformatf("blue at (%0d,%0d)", x, y), vga_b,
                      show_gray ? row.exp_gray : row.exp_b);
    endtask

    // one frame from a vsync fall to the next with the caller at the first fall
    task automatic scan_frame(input bit show_gray);
        logic prev_vsync;
        logic prev_hsync;
        logic prev_blank;
        int   x;
        int   y;
        int   cycles;
        int   vs_low;
        int   hs_low;
        int   hs_pulses;
        bit   frame_done;
        prev_vsync = 1'b0;                        // fall sample already seen
        prev_hsync = 1'b1;
        prev_blank = 1'b0;
        x          = 0;
        y          = 0;
        cycles     = 0;
        vs_low     = 1;
        hs_low     = 0;
        hs_pulses  = 0;
        frame_done = 1'b0;
        while (!frame_done) begin
            @(negedge clk_25_vga);                // outputs settled
            cycles++;
            if (cycles > FRAME_CYCLES + 8) begin
                report_error("timeout scanning a frame, vga_vsync did not fall again");
            end
            if (prev_vsync && !vga_vsync) begin
                frame_done = 1'b1;
            end else begin
                if (!vga_vsync) begin
                    vs_low++;
                end else if (!prev_vsync) begin
                    check_count("vsync low cycles", vs_low, V_SYNC * H_TOTAL);
                end
                if (!vga_hsync) begin
                    hs_low++;
                end else if (!prev_hsync) begin
                    check_count("hsync low cycles", hs_low, H_SYNC);
                    hs_low = 0;
                    hs_pulses++;
                end
                if (vga_blank_n) begin
                    check_pixel(x, y, show_gray);
                    x++;
                end else begin
                    check_channel("red while blanked", vga_r, '0);
                    check_channel("green while blanked", vga_g, '0);
                    check_channel("blue while blanked", vga_b, '0);
                    if (prev_blank) begin         // end of a visible line
                        check_count("active cycles in line", x, H_ACTIVE);
                        x = 0;
                        y++;
                    end
                end
                prev_vsync = vga_vsync;
                prev_hsync = vga_hsync;
                prev_blank = vga_blank_n;
            end
        end
        check_count("active lines in frame", y, V_ACTIVE);
        check_count("hsync pulses in frame", hs_pulses, V_TOTAL);
        check_count("cycles in frame", cycles, FRAME_CYCLES);
    endtask

    initial begin
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        mode    = cam_display_pkg::MODE_COLOR;
        build_table();
        check_reset_state();
        load_image();
        wait_vsync_fall();                        // first frame may show a partial image
        scan_frame(1'b0);
        @(posedge clk_25_vga);
        mode <= cam_display_pkg::MODE_GRAY;
        scan_frame(1'b1);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- filelist.f
common/cam_display_pkg.sv
source/raster_timing.sv
frame_buffer/frame_buffer_bank.sv
frame_buffer/frame_buffer.sv
source/pixel_color.sv
source/output_select.sv
source/cam_display_top.sv
test/tb_clock_gen.sv
test/tb_cam_display.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the display testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
FAIL_MSG="FAIL: see errors above"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cam_display --Mdir obj_dir -o tb_sim \
    -f filelist.f > "$BUILD_LOG" 2>&1
status=$?
cat "$BUILD_LOG"
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "$FAIL_MSG" "$SIM_LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
